/* flist.f */
+incdir+include
hdl/system_pkg.sv
hdl/axil_addr_router.sv
hdl/axil_to_mem.sv
hdl/l2_mem.sv
hdl/bootrom.sv
hdl/ctrl_registers.sv
hdl/mempool_system.sv
verification/tb_mempool_system.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_mempool_system -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_mempool_system)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verification/tb_mempool_system.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module tb_mempool_system;

  localparam int num_l2_tests  = 16;
  localparam int num_ext_tests = 4;
  localparam int drive_delay   = 5;
  // L2 fill, write and read per word, boot ROM, control registers, external port
  localparam int num_tx = 3 * num_l2_tests + `BOOT_WORDS + 3 + 15 + 2 * num_ext_tests + 1;
  localparam int timeout_ns = (num_tx * 20 + 100) * 40;  // 20 cycles each plus margin

  logic                   clk = 1'b0;
  logic                   rst_n;
  system_pkg::axil_req_t  host_req;
  system_pkg::axil_resp_t host_resp;
  system_pkg::axil_req_t  ext_req;
  system_pkg::axil_resp_t ext_resp;
  system_pkg::core_mask_t wake_up;
  logic                   eoc_valid;
  logic                   busy;

  integer                 seed = 32'hc9f74029;
  system_pkg::addr_t      ext_waddr;                   // Last addresses seen by the external slave
  system_pkg::addr_t      ext_raddr;
  system_pkg::data_t      ext_wdata;
  system_pkg::core_mask_t last_wake;
  int                     wake_cnt = 0;                // Cycles with any wake-up bit high
  logic                   wr_open;
  logic                   rd_open;
  logic                   wr_go = 1'b0;
  logic                   wr_end = 1'b0;
  logic                   rd_go = 1'b0;
  logic                   rd_end = 1'b0;
  logic [1:0]             open_cnt;

  mempool_system dut_i (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .host_req_i (host_req ),
    .host_resp_o(host_resp),
    .ext_req_o  (ext_req  ),
    .ext_resp_i (ext_resp ),
    .wake_up_o  (wake_up  ),
    .eoc_valid_o(eoc_valid),
    .busy_o     (busy     )
  );

  always #20 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("Fail @ %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
      else stop_on_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  function automatic int pick_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  // Only strobed bytes of the new word land in the old one
  function automatic system_pkg::data_t merge_strobed(system_pkg::data_t old_w,
                                                      system_pkg::data_t new_w,
                                                      system_pkg::strb_t strb);
    system_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic write_word(input system_pkg::addr_t addr, input system_pkg::data_t data,
                            input system_pkg::strb_t strb, input int hold,
                            output system_pkg::resp_t resp, output int lat);
    logic aw_hs;
    logic w_hs;
    int   rounds;
    int   cycles;
    rounds            = (hold > 0) ? 2 : 1;
    host_req.aw_addr  = addr;
    host_req.w_data   = data;
    host_req.w_strb   = strb;
    host_req.aw_valid = 1'b1;
    host_req.w_valid  = 1'b1;
    for (int n = 0; n < rounds; n++) begin
      while (host_req.aw_valid || host_req.w_valid) begin
        @(negedge clk);
        aw_hs = host_req.aw_valid && host_resp.aw_ready;
        w_hs  = host_req.w_valid && host_resp.w_ready;
        next_cycle();
        if (aw_hs) host_req.aw_valid = 1'b0;
        if (w_hs) host_req.w_valid = 1'b0;
      end
      cycles = 1;
      @(negedge clk);
      while (!host_resp.b_valid) begin
        @(negedge clk);
        cycles++;
      end
      if (n == 0) begin
        resp = host_resp.b_resp;
        lat  = cycles;
      end
      next_cycle();
      if (n == 0 && hold > 0) begin
        host_req.aw_valid = 1'b1;                      // Same write offered again while B is held
        host_req.w_valid  = 1'b1;
        repeat (hold) next_cycle();
      end
      host_req.b_ready = 1'b1;
      next_cycle();
      host_req.b_ready = 1'b0;
    end
  endtask

  task automatic read_word(input system_pkg::addr_t addr, input int hold,
                           output system_pkg::data_t data, output system_pkg::resp_t resp,
                           output int lat);
    int rounds;
    int cycles;
    rounds            = (hold > 0) ? 2 : 1;
    host_req.ar_addr  = addr;
    host_req.ar_valid = 1'b1;
    for (int n = 0; n < rounds; n++) begin
      @(negedge clk);
      while (!host_resp.ar_ready) begin
        next_cycle();
        @(negedge clk);
      end
      next_cycle();
      host_req.ar_valid = 1'b0;
      cycles = 1;
      @(negedge clk);
      while (!host_resp.r_valid) begin
        @(negedge clk);
        cycles++;
      end
      if (n == 0) begin
        data = host_resp.r_data;
        resp = host_resp.r_resp;
        lat  = cycles;
      end
      next_cycle();
      if (n == 0 && hold > 0) begin
        host_req.ar_valid = 1'b1;                      // Same read offered again while R is held
        repeat (hold) next_cycle();
      end
      host_req.r_ready = 1'b1;
      next_cycle();
      host_req.r_ready = 1'b0;
    end
  endtask

  // External slave, one transaction at a time after a random delay
  initial begin : ext_slave
    forever begin
      @(negedge clk);
      if (ext_req.aw_valid && ext_req.w_valid) begin
        ext_waddr = ext_req.aw_addr;
        ext_wdata = ext_req.w_data;
        repeat (pick_delay()) next_cycle();
        next_cycle();
        ext_resp.aw_ready = 1'b1;
        ext_resp.w_ready  = 1'b1;
        next_cycle();
        ext_resp.aw_ready = 1'b0;
        ext_resp.w_ready  = 1'b0;
        ext_resp.b_resp   = `RESP_OKAY;
        ext_resp.b_valid  = 1'b1;
        @(negedge clk);
        while (!ext_req.b_ready) @(negedge clk);
        next_cycle();
        ext_resp.b_valid = 1'b0;
      end else if (ext_req.ar_valid) begin
        ext_raddr = ext_req.ar_addr;
        repeat (pick_delay()) next_cycle();
        next_cycle();
        ext_resp.ar_ready = 1'b1;
        next_cycle();
        ext_resp.ar_ready = 1'b0;
        ext_resp.r_data   = ext_raddr ^ 32'h5A5A_5A5A;
        ext_resp.r_resp   = `RESP_OKAY;
        ext_resp.r_valid  = 1'b1;
        @(negedge clk);
        while (!ext_req.r_ready) @(negedge clk);
        next_cycle();
        ext_resp.r_valid = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (|wake_up) begin
      wake_cnt  = wake_cnt + 1;
      last_wake = wake_up;
    end
    wr_go  = (host_req.aw_valid && host_resp.aw_ready) || (host_req.w_valid && host_resp.w_ready);
    wr_end = host_resp.b_valid && host_req.b_ready;
    rd_go  = host_req.ar_valid && host_resp.ar_ready;
    rd_end = host_resp.r_valid && host_req.r_ready;
  end

  // Own count of open host transactions, updated on the transfer edge
  always @(posedge clk) begin
    if (!rst_n) begin
      wr_open <= 1'b0;
      rd_open <= 1'b0;
    end else begin
      if (wr_end) wr_open <= 1'b0;
      else if (wr_go) wr_open <= 1'b1;
      if (rd_end) rd_open <= 1'b0;
      else if (rd_go) rd_open <= 1'b1;
    end
  end

  assign open_cnt = wr_open + rd_open;

  a_busy: assert property (@(posedge clk) disable iff (!rst_n) busy == (open_cnt != 0))
    else stop_on_error("busy_o does not match the open transaction count");
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    host_resp.b_valid && !host_req.b_ready |=> host_resp.b_valid && $stable(host_resp.b_resp))
    else stop_on_error("B response dropped or changed while stalled");
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    host_resp.r_valid && !host_req.r_ready |=>
      host_resp.r_valid && $stable(host_resp.r_data) && $stable(host_resp.r_resp))
    else stop_on_error("R response dropped or changed while stalled");
  a_aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    host_resp.b_valid && !host_req.b_ready |-> !host_resp.aw_ready && !host_resp.w_ready)
    else stop_on_error("Write accepted while a B response is pending");
  a_ar_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    host_resp.r_valid && !host_req.r_ready |-> !host_resp.ar_ready)
    else stop_on_error("Read accepted while an R response is pending");

  initial begin : stimulus
    system_pkg::data_t rdata;
    system_pkg::data_t data;
    system_pkg::resp_t resp;
    system_pkg::strb_t strb;
    system_pkg::addr_t addr;
    int                lat;
    int                wake_before;
    int                idx [num_l2_tests];
    system_pkg::data_t shadow [`L2_WORDS];
    system_pkg::data_t layout [3];
    host_req = '0;
    ext_resp = '0;
    rst_n    = 1'b0;
    repeat (4) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    @(negedge clk);
    check_value({host_resp.aw_ready, host_resp.w_ready, host_resp.b_valid, host_resp.ar_ready,
                 host_resp.r_valid, ext_req.aw_valid, ext_req.w_valid, ext_req.ar_valid,
                 eoc_valid, wake_up, busy}, '0, "Valid and ready outputs after reset");
    next_cycle();

    for (int k = 0; k < num_l2_tests; k++) begin  // Touched words first get an address pattern
      idx[k]         = $unsigned($random(seed)) % `L2_WORDS;
      addr           = `L2_BASE + 4 * idx[k];
      shadow[idx[k]] = addr ^ 32'hC3C3_C3C3;
      write_word(addr, shadow[idx[k]], 4'hF, pick_delay(), resp, lat);
      check_value(resp, `RESP_OKAY, "L2 fill response");
      check_value(lat, 1, "L2 fill latency");
    end
    for (int k = 0; k < num_l2_tests; k++) begin
      data           = system_pkg::data_t'($random(seed));
      strb           = system_pkg::strb_t'($random(seed));
      write_word(`L2_BASE + 4 * idx[k], data, strb, pick_delay(), resp, lat);
      shadow[idx[k]] = merge_strobed(shadow[idx[k]], data, strb);
      check_value(resp, `RESP_OKAY, "L2 write response");
      check_value(lat, 1, "L2 write latency");
    end
    for (int k = 0; k < num_l2_tests; k++) begin
      read_word(`L2_BASE + 4 * idx[k], pick_delay(), rdata, resp, lat);
      check_value(rdata, shadow[idx[k]], $sformatf("L2 word %0d", idx[k]));
      check_value(resp, `RESP_OKAY, "L2 read response");
      check_value(lat, 1, "L2 read latency");
    end

    for (int i = 0; i < `BOOT_WORDS; i++) begin
      read_word(`BOOT_BASE + 4 * i, pick_delay(), rdata, resp, lat);
      check_value(rdata, 32'hB007_0000 + i, $sformatf("Boot ROM word %0d", i));
      check_value(resp, `RESP_OKAY, "Boot ROM read response");
      check_value(lat, 1, "Boot ROM read latency");
    end
    read_word(`BOOT_BASE + 4 * (`BOOT_WORDS + 3), 0, rdata, resp, lat);
    check_value(rdata, 32'hB007_0003, "Boot ROM wrapped word");
    write_word(`BOOT_BASE + 20, 32'hDEAD_BEEF, 4'hF, 0, resp, lat);
    check_value(resp, `RESP_SLVERR, "Boot ROM write response");
    read_word(`BOOT_BASE + 20, 0, rdata, resp, lat);
    check_value(rdata, 32'hB007_0005, "Boot ROM word after write");

    layout[0] = `TCDM_BASE;
    layout[1] = `TCDM_BASE + `TCDM_SIZE;
    layout[2] = `SYS_NUM_CORES;
    for (int r = 0; r < 3; r++) begin  // TCDM_START, TCDM_END, NUM_CORES
      addr = `CTRL_BASE + 8 + 4 * r;
      read_word(addr, pick_delay(), rdata, resp, lat);
      check_value(rdata, layout[r], $sformatf("Layout register %0d", r));
      check_value(resp, `RESP_OKAY, "Layout read response");
      write_word(addr, 32'hFFFF_FFFF, 4'hF, 0, resp, lat);
      check_value(resp, `RESP_SLVERR, "Layout write response");
      read_word(addr, 0, rdata, resp, lat);
      check_value(rdata, layout[r], "Layout register after write");
    end
    read_word(`CTRL_BASE + 32'h40, 0, rdata, resp, lat);
    check_value(rdata, 0, "Unmapped register data");
    check_value(resp, `RESP_SLVERR, "Unmapped register response");

    wake_before = wake_cnt;
    write_word(`CTRL_BASE + 4, 32'h0000_000A, 4'hF, 0, resp, lat);
    check_value(resp, `RESP_OKAY, "WAKE_UP write response");
    check_value(wake_cnt, wake_before + 1, "Wake-up pulse length in cycles");
    check_value(last_wake, 4'hA, "Wake-up mask");
    read_word(`CTRL_BASE + 4, 0, rdata, resp, lat);
    check_value(rdata, 0, "WAKE_UP read value");
    write_word(`CTRL_BASE, 32'h0000_CAF1, 4'hF, pick_delay(), resp, lat);
    check_value(resp, `RESP_OKAY, "EOC write response");
    check_value(eoc_valid, 1'b1, "eoc_valid_o after EOC write with bit 0 set");
    read_word(`CTRL_BASE, 0, rdata, resp, lat);
    check_value(rdata, 32'h0000_CAF1, "EOC read value");
    write_word(`CTRL_BASE, 32'h0000_CAF0, 4'hF, 0, resp, lat);
    check_value(eoc_valid, 1'b0, "eoc_valid_o after EOC write with bit 0 clear");

    for (int k = 0; k < num_ext_tests; k++) begin
      addr = (system_pkg::addr_t'($random(seed)) & 32'h0FFF_FFFC) | 32'h6000_0000;
      data = system_pkg::data_t'($random(seed));
      write_word(addr, data, 4'hF, pick_delay(), resp, lat);
      check_value(resp, `RESP_OKAY, "External write response");
      check_value(ext_waddr, addr, "External write address");
      check_value(ext_wdata, data, "External write data");
      addr = (system_pkg::addr_t'($random(seed)) & 32'h0FFF_FFFC) | 32'h2000_0000;
      read_word(addr, pick_delay(), rdata, resp, lat);
      check_value(ext_raddr, addr, "External read address");
      check_value(rdata, addr ^ 32'h5A5A_5A5A, "External read data");
      check_value(resp, `RESP_OKAY, "External read response");
    end
    read_word(`L2_END + 1, pick_delay(), rdata, resp, lat);  // First byte past the L2 window
    check_value(ext_raddr, `L2_END + 1, "External address past L2");
    check_value(rdata, (`L2_END + 1) ^ 32'h5A5A_5A5A, "External data past L2");

    repeat (2) next_cycle();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule : tb_mempool_system

/* hdl/mempool_system.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module mempool_system (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  system_pkg::axil_req_t  host_req_i,
  output system_pkg::axil_resp_t host_resp_o,
  output system_pkg::axil_req_t  ext_req_o,
  input  system_pkg::axil_resp_t ext_resp_i,
  output system_pkg::core_mask_t wake_up_o,
  output logic                   eoc_valid_o,
  output logic                   busy_o
);

  system_pkg::axil_req_t  tgt_req  [`SYS_NUM_TARGETS];
  system_pkg::axil_resp_t tgt_resp [`SYS_NUM_TARGETS];

  logic              l2_req;
  logic              l2_we;
  system_pkg::addr_t l2_addr;
  system_pkg::data_t l2_wdata;
  system_pkg::strb_t l2_strb;
  system_pkg::data_t l2_rdata;

  logic              boot_req;
  system_pkg::addr_t boot_addr;
  system_pkg::data_t boot_rdata;

  axil_addr_router i_router (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .host_req_i (host_req_i ),
    .host_resp_o(host_resp_o),
    .tgt_req_o  (tgt_req    ),
    .tgt_resp_i (tgt_resp   ),
    .busy_o     (busy_o     )
  );

  // Everything outside the mapped windows leaves through the external port
  assign ext_req_o                      = tgt_req[system_pkg::EXTERNAL];
  assign tgt_resp[system_pkg::EXTERNAL] = ext_resp_i;

  axil_to_mem #(
    .WriteEnable(1'b1)
  ) i_axi2mem_l2mem (
    .clk_i      (clk_i                           ),
    .rst_n_i    (rst_n_i                         ),
    .axi_req_i  (tgt_req[system_pkg::L2_MEMORY]  ),
    .axi_resp_o (tgt_resp[system_pkg::L2_MEMORY] ),
    .mem_req_o  (l2_req                          ),
    .mem_we_o   (l2_we                           ),
    .mem_addr_o (l2_addr                         ),
    .mem_wdata_o(l2_wdata                        ),
    .mem_strb_o (l2_strb                         ),
    .mem_rdata_i(l2_rdata                        )
  );

  l2_mem #(
    .NumWords(`L2_WORDS)
  ) i_l2_mem (
    .clk_i  (clk_i   ),
    .req_i  (l2_req  ),
    .we_i   (l2_we   ),
    .addr_i (l2_addr ),
    .wdata_i(l2_wdata),
    .strb_i (l2_strb ),
    .rdata_o(l2_rdata)
  );

  axil_to_mem #(
    .WriteEnable(1'b0)                                 // Writes get SLVERR
  ) i_axi2mem_bootrom (
    .clk_i      (clk_i                         ),
    .rst_n_i    (rst_n_i                       ),
    .axi_req_i  (tgt_req[system_pkg::BOOTROM]  ),
    .axi_resp_o (tgt_resp[system_pkg::BOOTROM] ),
    .mem_req_o  (boot_req                      ),
    .mem_we_o   (                              ),
    .mem_addr_o (boot_addr                     ),
    .mem_wdata_o(                              ),
    .mem_strb_o (                              ),
    .mem_rdata_i(boot_rdata                    )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i     ),
    .req_i  (boot_req  ),
    .addr_i (boot_addr ),
    .rdata_o(boot_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i                           ),
    .rst_n_i    (rst_n_i                         ),
    .axi_req_i  (tgt_req[system_pkg::CTRL_REGS]  ),
    .axi_resp_o (tgt_resp[system_pkg::CTRL_REGS] ),
    .wake_up_o  (wake_up_o                       ),
    .eoc_o      (                                ),  // Only visible over the bus
    .eoc_valid_o(eoc_valid_o                     )
  );

endmodule : mempool_system

/* hdl/ctrl_registers.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module ctrl_registers (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  system_pkg::axil_req_t  axi_req_i,
  output system_pkg::axil_resp_t axi_resp_o,
  output system_pkg::core_mask_t wake_up_o,
  output system_pkg::data_t      eoc_o,
  output logic                   eoc_valid_o
);

  localparam logic [15:0] OffEoc       = 16'h0000;
  localparam logic [15:0] OffWakeUp    = 16'h0004;
  localparam logic [15:0] OffTcdmStart = 16'h0008;
  localparam logic [15:0] OffTcdmEnd   = 16'h000C;
  localparam logic [15:0] OffNumCores  = 16'h0010;

  logic                   wr_acc;
  logic                   rd_acc;
  logic                   b_valid_q;
  logic                   r_valid_q;
  system_pkg::resp_t      b_resp_q;
  system_pkg::resp_t      r_resp_q;
  system_pkg::data_t      r_data_q;
  system_pkg::data_t      eoc_q;
  system_pkg::data_t      eoc_next;
  logic                   eoc_valid_q;
  system_pkg::core_mask_t wake_up_q;
  system_pkg::data_t      rd_data;
  system_pkg::resp_t      rd_resp;

  assign wr_acc = axi_req_i.aw_valid & axi_req_i.w_valid & ~b_valid_q;
  assign rd_acc = axi_req_i.ar_valid & ~r_valid_q;

  always_comb begin
    eoc_next = eoc_q;
    for (int b = 0; b < `SYS_DATA_W / 8; b++) begin
      if (axi_req_i.w_strb[b]) begin
        eoc_next[8*b +: 8] = axi_req_i.w_data[8*b +: 8];
      end
    end
  end

  always_comb begin
    rd_resp = `RESP_OKAY;
    case (axi_req_i.ar_addr[15:0])
      OffEoc:       rd_data = eoc_q;
      OffWakeUp:    rd_data = '0;                      // Write-only
      OffTcdmStart: rd_data = `TCDM_BASE;
      OffTcdmEnd:   rd_data = `TCDM_BASE + `TCDM_SIZE;
      OffNumCores:  rd_data = `SYS_NUM_CORES;
      default: begin
        rd_data = '0;
        rd_resp = `RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q   <= 1'b0;
      r_valid_q   <= 1'b0;
      eoc_q       <= '0;
      eoc_valid_q <= 1'b0;
      wake_up_q   <= '0;
    end else begin
      wake_up_q <= '0;                                 // Single-cycle pulse
      if (wr_acc) begin
        b_valid_q <= 1'b1;
        case (axi_req_i.aw_addr[15:0])
          OffEoc: begin
            eoc_q       <= eoc_next;
            eoc_valid_q <= eoc_next[0];
          end
          OffWakeUp: wake_up_q <= axi_req_i.w_data[`SYS_NUM_CORES-1:0];
          default: ;
        endcase
      end else if (b_valid_q && axi_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_acc) begin
        r_valid_q <= 1'b1;
      end else if (r_valid_q && axi_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      b_resp_q <= (axi_req_i.aw_addr[15:0] == OffEoc ||
                   axi_req_i.aw_addr[15:0] == OffWakeUp) ? `RESP_OKAY : `RESP_SLVERR;
    end
    if (rd_acc) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  always_comb begin
    axi_resp_o          = '0;
    axi_resp_o.aw_ready = wr_acc;
    axi_resp_o.w_ready  = wr_acc;
    axi_resp_o.b_valid  = b_valid_q;
    axi_resp_o.b_resp   = b_resp_q;
    axi_resp_o.ar_ready = ~r_valid_q;
    axi_resp_o.r_valid  = r_valid_q;
    axi_resp_o.r_data   = r_data_q;
    axi_resp_o.r_resp   = r_resp_q;
  end

  assign wake_up_o   = wake_up_q;
  assign eoc_o       = eoc_q;
  assign eoc_valid_o = eoc_valid_q;

  // Pending B blocks the next write, so two pulses can never touch
  a_wake_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |wake_up_o |=> !(|wake_up_o))
    else $error("wake_up_o high for two cycles");

endmodule : ctrl_registers

/* hdl/bootrom.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module bootrom (
  input  logic              clk_i,
  input  logic              req_i,
  input  system_pkg::addr_t addr_i,                    // Word index
  output system_pkg::data_t rdata_o
);

  localparam int unsigned IdxW = $clog2(`BOOT_WORDS);

  system_pkg::data_t rom [`BOOT_WORDS];

  for (genvar i = 0; i < `BOOT_WORDS; i++) begin : gen_rom
    assign rom[i] = system_pkg::data_t'(`BOOT_TAG + i);
  end

  // Upper index bits are dropped so the table repeats across the window
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom[addr_i[IdxW-1:0]];
    end
  end

endmodule : bootrom

/* hdl/l2_mem.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module l2_mem #(
  parameter int unsigned NumWords = 256
) (
  input  logic              clk_i,
  input  logic              req_i,
  input  logic              we_i,
  input  system_pkg::addr_t addr_i,                    // Word index
  input  system_pkg::data_t wdata_i,
  input  system_pkg::strb_t strb_i,
  output system_pkg::data_t rdata_o
);

  localparam int unsigned IdxW = $clog2(NumWords);

  system_pkg::data_t mem_q [NumWords];
  logic [IdxW-1:0]   idx;

  assign idx = addr_i[IdxW-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < `SYS_DATA_W / 8; b++) begin
          if (strb_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];                         // Only reads move the output
      end
    end
  end

endmodule : l2_mem

/* hdl/axil_to_mem.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module axil_to_mem #(
  parameter bit WriteEnable = 1'b1                     // 0 turns the port read-only
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  system_pkg::axil_req_t  axi_req_i,
  output system_pkg::axil_resp_t axi_resp_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output system_pkg::addr_t      mem_addr_o,
  output system_pkg::data_t      mem_wdata_o,
  output system_pkg::strb_t      mem_strb_o,
  input  system_pkg::data_t      mem_rdata_i
);

  logic b_valid_q;
  logic r_valid_q;
  logic rd_acc;
  logic wr_acc;

  assign rd_acc = axi_req_i.ar_valid & ~r_valid_q;
  // Single memory port, a read in the same cycle goes first
  assign wr_acc = axi_req_i.aw_valid & axi_req_i.w_valid & ~b_valid_q &
                  ~(WriteEnable & rd_acc);

  assign mem_we_o    = WriteEnable & wr_acc;
  assign mem_req_o   = mem_we_o | rd_acc;
  assign mem_addr_o  = mem_we_o ? {2'b00, axi_req_i.aw_addr[`SYS_ADDR_W-1:2]}
                                : {2'b00, axi_req_i.ar_addr[`SYS_ADDR_W-1:2]};  // Word index
  assign mem_wdata_o = axi_req_i.w_data;
  assign mem_strb_o  = axi_req_i.w_strb;

  always_comb begin
    axi_resp_o          = '0;
    axi_resp_o.aw_ready = wr_acc;
    axi_resp_o.w_ready  = wr_acc;
    axi_resp_o.b_valid  = b_valid_q;
    axi_resp_o.b_resp   = WriteEnable ? `RESP_OKAY : `RESP_SLVERR;
    axi_resp_o.ar_ready = ~r_valid_q;
    axi_resp_o.r_valid  = r_valid_q;
    axi_resp_o.r_data   = mem_rdata_i;                 // Memory holds it until the next read
    axi_resp_o.r_resp   = `RESP_OKAY;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_acc) begin
        b_valid_q <= 1'b1;
      end else if (b_valid_q && axi_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_acc) begin
        r_valid_q <= 1'b1;
      end else if (r_valid_q && axi_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // A new response only ever follows a request handshake at the port one cycle earlier
  a_b_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(axi_resp_o.b_valid) |->
      $past(axi_req_i.aw_valid && axi_resp_o.aw_ready &&
            axi_req_i.w_valid && axi_resp_o.w_ready))
    else $error("B raised without an accepted write");
  a_r_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(axi_resp_o.r_valid) |-> $past(axi_req_i.ar_valid && axi_resp_o.ar_ready))
    else $error("R raised without an accepted read");

endmodule : axil_to_mem

/* hdl/axil_addr_router.sv */
`timescale 1ns/100ps
`include "system_params.svh"

module axil_addr_router (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  system_pkg::axil_req_t  host_req_i,
  output system_pkg::axil_resp_t host_resp_o,
  output system_pkg::axil_req_t  tgt_req_o [`SYS_NUM_TARGETS],
  input  system_pkg::axil_resp_t tgt_resp_i [`SYS_NUM_TARGETS],
  output logic                   busy_o
);

  function automatic system_pkg::slv_target_e decode(system_pkg::addr_t addr);
    system_pkg::slv_target_e tgt;
    if (addr >= `CTRL_BASE && addr <= `CTRL_END) begin
      tgt = system_pkg::CTRL_REGS;
    end else if (addr >= `L2_BASE && addr <= `L2_END) begin
      tgt = system_pkg::L2_MEMORY;
    end else if (addr >= `BOOT_BASE && addr <= `BOOT_END) begin
      tgt = system_pkg::BOOTROM;
    end else begin
      tgt = system_pkg::EXTERNAL;
    end
    return tgt;
  endfunction

  logic                    w_out_q;                    // Write in flight until B transfers
  logic                    aw_done_q;
  logic                    w_done_q;
  system_pkg::slv_target_e w_tgt_q;
  logic                    r_out_q;
  system_pkg::slv_target_e r_tgt_q;

  system_pkg::slv_target_e w_sel;
  system_pkg::slv_target_e r_sel;
  logic                    fwd_aw_valid;
  logic                    fwd_w_valid;
  logic                    fwd_ar_valid;
  logic                    aw_hs;
  logic                    w_hs;
  logic                    b_hs;
  logic                    ar_hs;
  logic                    r_hs;

  assign w_sel = w_out_q ? w_tgt_q : decode(host_req_i.aw_addr);
  assign r_sel = r_out_q ? r_tgt_q : decode(host_req_i.ar_addr);

  // A new write starts with AW and W together, a slow slave may take them apart
  assign fwd_aw_valid = host_req_i.aw_valid & (w_out_q ? ~aw_done_q : host_req_i.w_valid);
  assign fwd_w_valid  = host_req_i.w_valid & (w_out_q ? ~w_done_q : host_req_i.aw_valid);
  assign fwd_ar_valid = host_req_i.ar_valid & ~r_out_q;

  assign aw_hs = fwd_aw_valid & tgt_resp_i[w_sel].aw_ready;
  assign w_hs  = fwd_w_valid & tgt_resp_i[w_sel].w_ready;
  assign b_hs  = w_out_q & tgt_resp_i[w_tgt_q].b_valid & host_req_i.b_ready;
  assign ar_hs = fwd_ar_valid & tgt_resp_i[r_sel].ar_ready;
  assign r_hs  = r_out_q & tgt_resp_i[r_tgt_q].r_valid & host_req_i.r_ready;

  always_comb begin
    for (int t = 0; t < `SYS_NUM_TARGETS; t++) begin
      tgt_req_o[t]          = host_req_i;              // Payload goes everywhere
      tgt_req_o[t].aw_valid = 1'b0;
      tgt_req_o[t].w_valid  = 1'b0;
      tgt_req_o[t].b_ready  = 1'b0;
      tgt_req_o[t].ar_valid = 1'b0;
      tgt_req_o[t].r_ready  = 1'b0;
    end
    tgt_req_o[w_sel].aw_valid = fwd_aw_valid;
    tgt_req_o[w_sel].w_valid  = fwd_w_valid;
    tgt_req_o[w_sel].b_ready  = w_out_q & host_req_i.b_ready;
    tgt_req_o[r_sel].ar_valid = fwd_ar_valid;
    tgt_req_o[r_sel].r_ready  = r_out_q & host_req_i.r_ready;
  end

  always_comb begin
    host_resp_o          = '0;
    host_resp_o.aw_ready = aw_hs;
    host_resp_o.w_ready  = w_hs;
    host_resp_o.b_valid  = w_out_q & tgt_resp_i[w_tgt_q].b_valid;
    host_resp_o.b_resp   = tgt_resp_i[w_tgt_q].b_resp;
    host_resp_o.ar_ready = ar_hs;
    host_resp_o.r_valid  = r_out_q & tgt_resp_i[r_tgt_q].r_valid;
    host_resp_o.r_data   = tgt_resp_i[r_tgt_q].r_data;
    host_resp_o.r_resp   = tgt_resp_i[r_tgt_q].r_resp;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      w_out_q   <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      w_tgt_q   <= system_pkg::CTRL_REGS;
      r_out_q   <= 1'b0;
      r_tgt_q   <= system_pkg::CTRL_REGS;
    end else begin
      if (!w_out_q) begin
        if (aw_hs || w_hs) begin
          w_out_q   <= 1'b1;
          w_tgt_q   <= w_sel;
          aw_done_q <= aw_hs;
          w_done_q  <= w_hs;
        end
      end else if (b_hs) begin
        w_out_q   <= 1'b0;
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        aw_done_q <= aw_done_q | aw_hs;
        w_done_q  <= w_done_q | w_hs;
      end
      if (ar_hs) begin
        r_out_q <= 1'b1;
        r_tgt_q <= r_sel;
      end else if (r_hs) begin
        r_out_q <= 1'b0;
      end
    end
  end

  assign busy_o = w_out_q | r_out_q;

  // Responses must come only from the target that owns the open transaction
  for (genvar t = 0; t < `SYS_NUM_TARGETS; t++) begin : gen_owner_chk
    a_b_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_resp_i[t].b_valid |-> (w_out_q && w_tgt_q == t))
      else $error("B response from target %0d without open write", t);
    a_r_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_resp_i[t].r_valid |-> (r_out_q && r_tgt_q == t))
      else $error("R response from target %0d without open read", t);
  end

endmodule : axil_addr_router

/* hdl/system_pkg.sv */
`include "system_params.svh"

package system_pkg;

  typedef logic [`SYS_ADDR_W-1:0]     addr_t;
  typedef logic [`SYS_DATA_W-1:0]     data_t;
  typedef logic [`SYS_DATA_W/8-1:0]   strb_t;
  typedef logic [1:0]                 resp_t;
  typedef logic [`SYS_NUM_CORES-1:0]  core_mask_t;

  // Master to slave
  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
  } axil_resp_t;

  typedef enum logic [1:0] {
    CTRL_REGS,
    L2_MEMORY,
    BOOTROM,
    EXTERNAL                               // Default route for unmapped addresses
  } slv_target_e;

endpackage : system_pkg

/* include/system_params.svh */
`ifndef SYSTEM_PARAMS_SVH
`define SYSTEM_PARAMS_SVH

`define SYS_ADDR_W      32
`define SYS_DATA_W      32
`define SYS_NUM_CORES   4                  // Also the width of the wake-up mask
`define SYS_NUM_TARGETS 4                  // Control regs, L2, boot ROM, external port

`define CTRL_BASE       32'h4000_0000
`define CTRL_END        32'h4000_FFFF
`define L2_BASE         32'h8000_0000
`define L2_END          32'h8000_03FF
`define BOOT_BASE       32'hA000_0000
`define BOOT_END        32'hA000_FFFF

`define L2_WORDS        256
`define BOOT_WORDS      16
`define BOOT_TAG        32'hB007_0000      // Upper half of every boot word

`define TCDM_BASE       32'h0000_0000      // Reported by the layout registers
`define TCDM_SIZE       32'h0001_0000

`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`endif
